// File: pol_top.f
pol_pkg.sv
pol_ctrl.sv
pol_core.sv
pol_merge.sv
pol_top.sv
tb_pol.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pooling testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pol \
    -f pol_top.f -o sim_pol \
    && ./obj_dir/sim_pol | tee sim.log \
    || { echo "Build or run error"; exit 1; }

grep -q "^ALL CHECKS PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb_pol.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pol;

    localparam int IDX_WIDTH = pol_pkg::IDX_WIDTH;
    localparam int ACT_WIDTH = pol_pkg::ACT_WIDTH;
    localparam int LANES     = pol_pkg::LANES;
    localparam int K_WIDTH   = pol_pkg::K_WIDTH;
    localparam logic [31:0] SEED = 32'hba2a_e2a4;
    // Cycle limits for the wait loops
    localparam int CFG_LIMIT = 100;
    localparam int MAP_LIMIT = 500;
    localparam int OUT_LIMIT = 4000;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_vld;
    logic                   cfg_rdy;
    pol_pkg::k_t            cfg_k;
    pol_pkg::idx_t          cfg_nip;
    logic                   map_vld;
    logic                   map_rdy;
    pol_pkg::map_t          map;
    logic [1:0]             addr_vld;
    logic [1:0]             addr_rdy;
    pol_pkg::idx_t [1:0]    addr;
    logic [1:0]             ofm_vld;
    logic [1:0]             ofm_rdy;
    pol_pkg::vec_t          ofm0;
    pol_pkg::vec_t          ofm1;
    logic                   out_vld;
    logic                   out_rdy;
    pol_pkg::vec_t          out;

    // ================================================
    // Testbench state
    // ================================================
    logic [31:0]    lfsr;
    pol_pkg::vec_t  act_mem [1024];
    pol_pkg::map_t  map_pool [64];
    int             map_next;
    logic           rand_mode;
    int             cyc;
    // Read queues of the memory model, per core
    pol_pkg::idx_t  rq_addr [2][4];
    int             rq_due [2][4];
    int             rq_head [2];
    int             rq_count [2];
    // Address log against the expected lane indices
    pol_pkg::idx_t  got_addr [2][64];
    pol_pkg::idx_t  exp_addr [2][64];
    int             n_addr [2];
    // Reference results of the current job
    pol_pkg::vec_t  exp_vec [64];
    int             job_nip;
    int             job_words;
    int             out_cnt;
    logic           hold_seen;
    pol_pkg::vec_t  held_out;
    int             errors;
    int             checks;
    int             tests_run;
    int             tests_failed;
    logic           hung;

    pol_top #(
        .IDX_WIDTH (IDX_WIDTH),
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .K_WIDTH   (K_WIDTH)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_vld  (cfg_vld),
        .cfg_rdy  (cfg_rdy),
        .cfg_k    (cfg_k),
        .cfg_nip  (cfg_nip),
        .map_vld  (map_vld),
        .map_rdy  (map_rdy),
        .map      (map),
        .addr_vld (addr_vld),
        .addr_rdy (addr_rdy),
        .addr     (addr),
        .ofm_vld  (ofm_vld),
        .ofm_rdy  (ofm_rdy),
        .ofm0     (ofm0),
        .ofm1     (ofm1),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out      (out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ================================================
    // Random source and reference helpers
    // ================================================
    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Unsigned maximum per lane
    function automatic pol_pkg::vec_t vec_max(input pol_pkg::vec_t a, input pol_pkg::vec_t b);
        pol_pkg::vec_t m;
        m = '0;
        for (int l = 0; l < LANES; l++) begin
            if (a[l*ACT_WIDTH +: ACT_WIDTH] > b[l*ACT_WIDTH +: ACT_WIDTH]) begin
                m[l*ACT_WIDTH +: ACT_WIDTH] = a[l*ACT_WIDTH +: ACT_WIDTH];
            end else begin
                m[l*ACT_WIDTH +: ACT_WIDTH] = b[l*ACT_WIDTH +: ACT_WIDTH];
            end
        end
        return m;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        hung = 1'b1;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before || hung) begin
            tests_failed++;
            $display("Test %0d %s: failed", num, name);
        end else begin
            $display("Test %0d %s: passed", num, name);
        end
    endtask

    // ================================================
    // Memory model and output ready
    // ================================================
    always @(posedge clk) begin
        logic [31:0] r;
        int          tail;
        int          head;
        if (!rst_n) begin
            addr_rdy <= 2'b00;
            ofm_vld  <= 2'b00;
            out_rdy  <= 1'b0;
        end else begin
            cyc = cyc + 1;
            for (int c = 0; c < 2; c++) begin
                // Read issued, response due after 0 to 3 cycles
                if (addr_vld[c] && addr_rdy[c]) begin
                    if (n_addr[c] < 64) got_addr[c][n_addr[c]] = addr[c];
                    n_addr[c]++;
                    r = '0;
                    if (rand_mode) draw_bits(2, r);
                    tail = (rq_head[c] + rq_count[c]) % 4;
                    rq_addr[c][tail] = addr[c];
                    rq_due[c][tail]  = cyc + int'(r);
                    rq_count[c]++;
                end
                if (ofm_vld[c] && ofm_rdy[c]) begin
                    rq_head[c] = (rq_head[c] + 1) % 4;
                    rq_count[c]--;
                end
                // Held response keeps its data
                if (!(ofm_vld[c] && !ofm_rdy[c])) begin
                    r = 32'h3;
                    if (rand_mode) draw_bits(2, r);
                    head = rq_head[c];
                    if (rq_count[c] != 0 && rq_due[c][head] <= cyc && r != 0) begin
                        ofm_vld[c] <= 1'b1;
                        if (c == 0) ofm0 <= act_mem[rq_addr[c][head]];
                        else ofm1 <= act_mem[rq_addr[c][head]];
                    end else begin
                        ofm_vld[c] <= 1'b0;
                    end
                end
                r = 32'h1;
                if (rand_mode) draw_bits(2, r);
                addr_rdy[c] <= (r != 0);
            end
            r = 32'h1;
            if (rand_mode) draw_bits(1, r);
            out_rdy <= r[0];
        end
    end

    // Output order, values and hold stability
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_seen) begin
                check_value("out_vld held", 32'd1, 32'(out_vld));
                check_value("out held", held_out, out);
            end
            if (out_vld && out_rdy) begin
                if (out_cnt < job_nip) begin
                    check_value($sformatf("out point %0d", out_cnt), exp_vec[out_cnt], out);
                end else begin
                    $display("Output transfer at %0t beyond the job's point count", $time);
                    errors++;
                end
                out_cnt <= out_cnt + 1;
            end
            hold_seen <= out_vld && !out_rdy;
            held_out  <= out;
        end
    end

    // ================================================
    // Handshake waits
    // ================================================
    task automatic take_config();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!cfg_rdy && waited < CFG_LIMIT);
        if (!cfg_rdy) note_timeout("configuration was never accepted");
    endtask

    task automatic push_map();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!map_rdy && waited < MAP_LIMIT);
        if (!map_rdy) note_timeout("map word was never accepted");
    endtask

    task automatic drain_outputs(input int nip);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (out_cnt < nip && waited < OUT_LIMIT);
        if (out_cnt < nip) note_timeout("not all pooled outputs arrived");
    endtask

    // ================================================
    // Job runner
    // ================================================
    task automatic run_job(input int k, input int nip, input logic rnd);
        int            n;
        int            p;
        pol_pkg::idx_t ie;
        pol_pkg::idx_t io;
        job_words = k * nip / 2;
        // Word j is neighbor j mod K of points 2(j div K) and 2(j div K)+1
        for (int j = 0; j < job_words; j++) begin
            {io, ie} = map_pool[map_next + j];
            n = j % k;
            p = 2 * (j / k);
            exp_addr[0][j] = ie;
            exp_addr[1][j] = io;
            exp_vec[p]     = (n == 0) ? act_mem[ie] : vec_max(exp_vec[p], act_mem[ie]);
            exp_vec[p+1]   = (n == 0) ? act_mem[io] : vec_max(exp_vec[p+1], act_mem[io]);
        end
        n_addr[0] = 0;
        n_addr[1] = 0;
        job_nip   = nip;
        @(posedge clk);
        out_cnt   <= 0;
        rand_mode <= rnd;
        cfg_vld   <= 1'b1;
        cfg_k     <= pol_pkg::k_t'(k);
        cfg_nip   <= pol_pkg::idx_t'(nip);
        take_config();
        cfg_vld <= 1'b0;
        if (hung) return;
        for (int j = 0; j < job_words; j++) begin
            map_vld <= 1'b1;
            map     <= map_pool[map_next + j];
            push_map();
            if (hung) return;
        end
        map_vld  <= 1'b0;
        map_next += job_words;
        drain_outputs(nip);
    endtask

    task automatic compare_addresses();
        for (int c = 0; c < 2; c++) begin
            check_value($sformatf("addr%0d count", c), 32'(job_words), 32'(n_addr[c]));
            for (int j = 0; j < job_words && j < n_addr[c]; j++) begin
                check_value($sformatf("addr%0d read %0d", c, j),
                            32'(exp_addr[c][j]), 32'(got_addr[c][j]));
            end
        end
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        int            e0;
        logic [31:0]   v;
        logic [31:0]   w;
        rst_n     = 1'b0;
        cfg_vld   = 1'b0;
        cfg_k     = '0;
        cfg_nip   = '0;
        map_vld   = 1'b0;
        map       = '0;
        addr_rdy  = 2'b00;
        ofm_vld   = 2'b00;
        ofm0      = '0;
        ofm1      = '0;
        out_rdy   = 1'b0;
        rand_mode = 1'b0;
        cyc       = 0;
        out_cnt   = 0;
        job_nip   = 0;
        job_words = 0;
        map_next  = 0;
        hold_seen = 1'b0;
        held_out  = '0;
        errors    = 0;
        checks    = 0;
        tests_run    = 0;
        tests_failed = 0;
        hung      = 1'b0;
        for (int c = 0; c < 2; c++) begin
            rq_head[c]  = 0;
            rq_count[c] = 0;
            n_addr[c]   = 0;
        end
        // Activation table, then the map words of every job
        lfsr = SEED;
        for (int a = 0; a < 1024; a++) begin
            draw_bits(32, v);
            act_mem[a] = v;
        end
        for (int i = 0; i < 64; i++) begin
            draw_bits(IDX_WIDTH, v);
            draw_bits(IDX_WIDTH, w);
            map_pool[i] = {w[IDX_WIDTH-1:0], v[IDX_WIDTH-1:0]};
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        e0 = errors;
        check_value("cfg_rdy", 32'd1, 32'(cfg_rdy));
        check_value("map_rdy", 32'd0, 32'(map_rdy));
        check_value("out_vld", 32'd0, 32'(out_vld));
        check_value("addr_vld", 32'd0, 32'(addr_vld));
        check_value("ofm_rdy", 32'd0, 32'(ofm_rdy));
        report_test(1, "reset values", e0);

        e0 = errors;
        run_job(4, 8, 1'b0);
        report_test(2, "job K=4 Nip=8 in point order", e0);

        if (!hung) begin
            e0 = errors;
            compare_addresses();
            report_test(3, "per-core address sequence", e0);
        end

        if (!hung) begin
            e0 = errors;
            run_job(4, 8, 1'b1);
            compare_addresses();
            report_test(4, "job K=4 Nip=8 under random stalls", e0);
        end

        // Idle between jobs, map offered but never taken
        if (!hung) begin
            e0 = errors;
            check_value("cfg_rdy after job", 32'd1, 32'(cfg_rdy));
            map_vld <= 1'b1;
            map     <= map_pool[0];
            repeat (4) begin
                @(posedge clk);
                check_value("map_rdy idle", 32'd0, 32'(map_rdy));
                check_value("cfg_rdy idle", 32'd1, 32'(cfg_rdy));
            end
            map_vld <= 1'b0;
            run_job(1, 6, 1'b1);
            compare_addresses();
            report_test(5, "idle gap and job K=1 Nip=6", e0);
        end

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !hung) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pol_top.sv
`timescale 1ns/10ps
`default_nettype none

module pol_top #(
    parameter int IDX_WIDTH = pol_pkg::IDX_WIDTH,
    parameter int ACT_WIDTH = pol_pkg::ACT_WIDTH,
    parameter int LANES     = pol_pkg::LANES,
    parameter int K_WIDTH   = pol_pkg::K_WIDTH
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // Job configuration
    input  wire logic              cfg_vld,
    output logic                   cfg_rdy,
    input  pol_pkg::k_t            cfg_k,
    input  pol_pkg::idx_t          cfg_nip,
    // Neighbor map stream
    input  wire logic              map_vld,
    output logic                   map_rdy,
    input  pol_pkg::map_t          map,
    // Memory ports, one per core
    output logic [1:0]             addr_vld,
    input  wire logic [1:0]        addr_rdy,
    output pol_pkg::idx_t [1:0]    addr,
    input  wire logic [1:0]        ofm_vld,
    output logic [1:0]             ofm_rdy,
    input  pol_pkg::vec_t          ofm0,
    input  pol_pkg::vec_t          ofm1,
    // Pooled vectors in point order
    output logic                   out_vld,
    input  wire logic              out_rdy,
    output pol_pkg::vec_t          out
);

    logic          clr;
    logic          idx_vld;
    pol_pkg::k_t   job_k;
    logic [1:0]    idx_rdy;
    logic [1:0]    res_vld;
    logic [1:0]    res_rdy;
    pol_pkg::vec_t res0;
    pol_pkg::vec_t res1;

    // ================================================
    // Controller
    // ================================================
    pol_ctrl #(
        .IDX_WIDTH (IDX_WIDTH),
        .K_WIDTH   (K_WIDTH)
    ) u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_vld (cfg_vld),
        .cfg_k   (cfg_k),
        .cfg_nip (cfg_nip),
        .map_vld (map_vld),
        .idx_rdy (idx_rdy),
        .out_vld (out_vld),
        .out_rdy (out_rdy),
        .cfg_rdy (cfg_rdy),
        .map_rdy (map_rdy),
        .idx_vld (idx_vld),
        .clr     (clr),
        .job_k   (job_k)
    );

    // ================================================
    // Pooling cores
    // ================================================
    // Even points, low half of the map word
    pol_core #(
        .IDX_WIDTH (IDX_WIDTH),
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .K_WIDTH   (K_WIDTH)
    ) u_core0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (clr),
        .job_k    (job_k),
        .idx_vld  (idx_vld),
        .idx      (map[IDX_WIDTH-1:0]),
        .addr_rdy (addr_rdy[0]),
        .ofm_vld  (ofm_vld[0]),
        .ofm      (ofm0),
        .res_rdy  (res_rdy[0]),
        .idx_rdy  (idx_rdy[0]),
        .addr_vld (addr_vld[0]),
        .addr     (addr[0]),
        .ofm_rdy  (ofm_rdy[0]),
        .res_vld  (res_vld[0]),
        .res      (res0)
    );

    // Odd points, high half
    pol_core #(
        .IDX_WIDTH (IDX_WIDTH),
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES),
        .K_WIDTH   (K_WIDTH)
    ) u_core1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (clr),
        .job_k    (job_k),
        .idx_vld  (idx_vld),
        .idx      (map[2*IDX_WIDTH-1:IDX_WIDTH]),
        .addr_rdy (addr_rdy[1]),
        .ofm_vld  (ofm_vld[1]),
        .ofm      (ofm1),
        .res_rdy  (res_rdy[1]),
        .idx_rdy  (idx_rdy[1]),
        .addr_vld (addr_vld[1]),
        .addr     (addr[1]),
        .ofm_rdy  (ofm_rdy[1]),
        .res_vld  (res_vld[1]),
        .res      (res1)
    );

    // ================================================
    // Ordered merge
    // ================================================
    pol_merge #(
        .ACT_WIDTH (ACT_WIDTH),
        .LANES     (LANES)
    ) u_merge (
        .clk     (clk),
        .rst_n   (rst_n),
        .clr     (clr),
        .res_vld (res_vld),
        .res0    (res0),
        .res1    (res1),
        .out_rdy (out_rdy),
        .res_rdy (res_rdy),
        .out_vld (out_vld),
        .out     (out)
    );

endmodule

`default_nettype wire

// File: pol_merge.sv
`timescale 1ns/10ps
`default_nettype none

module pol_merge #(
    parameter int ACT_WIDTH = pol_pkg::ACT_WIDTH,
    parameter int LANES     = pol_pkg::LANES
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        clr,
    input  wire logic [1:0]  res_vld,
    input  pol_pkg::vec_t    res0,
    input  pol_pkg::vec_t    res1,
    input  wire logic        out_rdy,
    output logic [1:0]       res_rdy,
    output logic             out_vld,
    output pol_pkg::vec_t    out
);

    // 0 means even point next, from core 0
    logic                       turn_q;
    logic                       out_full;
    logic [ACT_WIDTH*LANES-1:0] out_q;
    logic [ACT_WIDTH*LANES-1:0] pick;
    logic                       take;
    logic                       out_fire;

    // ================================================
    // Ordered pick
    // ================================================
    // Only the core whose turn it is may hand over
    assign res_rdy[0] = !out_full && !turn_q;
    assign res_rdy[1] = !out_full && turn_q;
    assign take       = |(res_vld & res_rdy);
    assign pick       = turn_q ? res1 : res0;

    assign out_vld    = out_full;
    assign out        = out_q;
    assign out_fire   = out_vld && out_rdy;

    // ================================================
    // Output register
    // ================================================
    always_ff @(posedge clk) begin
        if (take) out_q <= pick;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            turn_q   <= 1'b0;
            out_full <= 1'b0;
        end else if (clr) begin
            turn_q   <= 1'b0;
            out_full <= 1'b0;
        end else if (take) begin
            out_full <= 1'b1;
        end else if (out_fire) begin
            // Swap cores after each point leaves
            out_full <= 1'b0;
            turn_q   <= ~turn_q;
        end
    end

endmodule

`default_nettype wire

// File: pol_core.sv
`timescale 1ns/10ps
`default_nettype none

module pol_core #(
    parameter int IDX_WIDTH = pol_pkg::IDX_WIDTH,
    parameter int ACT_WIDTH = pol_pkg::ACT_WIDTH,
    parameter int LANES     = pol_pkg::LANES,
    parameter int K_WIDTH   = pol_pkg::K_WIDTH
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      clr,
    input  pol_pkg::k_t    job_k,
    input  wire logic      idx_vld,
    input  pol_pkg::idx_t  idx,
    input  wire logic      addr_rdy,
    input  wire logic      ofm_vld,
    input  pol_pkg::vec_t  ofm,
    input  wire logic      res_rdy,
    output logic           idx_rdy,
    output logic           addr_vld,
    output pol_pkg::idx_t  addr,
    output logic           ofm_rdy,
    output logic           res_vld,
    output pol_pkg::vec_t  res
);

    // Index buffer, two entries
    logic [IDX_WIDTH-1:0]       buf_mem [2];
    logic                       wr_ptr;
    logic                       rd_ptr;
    logic [1:0]                 buf_cnt;
    // Reads in flight
    logic [1:0]                 pend_cnt;
    // Running maximum state
    logic [ACT_WIDTH*LANES-1:0] max_q;
    logic [ACT_WIDTH*LANES-1:0] fold;
    logic [K_WIDTH-1:0]         nb_cnt;
    logic [K_WIDTH-1:0]         k_last;
    // Finished vector
    logic [ACT_WIDTH*LANES-1:0] res_q;
    logic                       res_full;
    logic                       idx_fire;
    logic                       addr_fire;
    logic                       ofm_fire;
    logic                       res_fire;

    // ================================================
    // Handshakes
    // ================================================
    assign idx_rdy   = (buf_cnt != 2'd2);
    assign addr_vld  = (buf_cnt != 2'd0) && (pend_cnt != 2'd2);
    assign addr      = buf_mem[rd_ptr];
    // No response taken while a result waits
    assign ofm_rdy   = (pend_cnt != 2'd0) && !res_full;
    assign res_vld   = res_full;
    assign res       = res_q;

    assign idx_fire  = idx_vld && idx_rdy;
    assign addr_fire = addr_vld && addr_rdy;
    assign ofm_fire  = ofm_vld && ofm_rdy;
    assign res_fire  = res_vld && res_rdy;

    // ================================================
    // Index buffer and read issue
    // ================================================
    always_ff @(posedge clk) begin
        if (idx_fire) buf_mem[wr_ptr] <= idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            buf_cnt  <= 2'd0;
            pend_cnt <= 2'd0;
        end else if (clr) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            buf_cnt  <= 2'd0;
            pend_cnt <= 2'd0;
        end else begin
            if (idx_fire) wr_ptr <= ~wr_ptr;
            // Entry freed once its address is taken
            if (addr_fire) rd_ptr <= ~rd_ptr;
            buf_cnt  <= buf_cnt + {1'b0, idx_fire} - {1'b0, addr_fire};
            pend_cnt <= pend_cnt + {1'b0, addr_fire} - {1'b0, ofm_fire};
        end
    end

    // ================================================
    // Lane-wise unsigned maximum
    // ================================================
    always_comb begin
        pol_pkg::act_t lane_in;
        pol_pkg::act_t lane_acc;
        fold = '0;
        for (int l = 0; l < LANES; l++) begin
            lane_in  = ofm[l*ACT_WIDTH +: ACT_WIDTH];
            lane_acc = max_q[l*ACT_WIDTH +: ACT_WIDTH];
            // First neighbor loads straight in
            if ((nb_cnt == '0) || (lane_in > lane_acc)) begin
                fold[l*ACT_WIDTH +: ACT_WIDTH] = lane_in;
            end else begin
                fold[l*ACT_WIDTH +: ACT_WIDTH] = lane_acc;
            end
        end
    end

    assign k_last = job_k - 1'b1;

    always_ff @(posedge clk) begin
        if (ofm_fire) begin
            max_q <= fold;
            if (nb_cnt == k_last) res_q <= fold;
        end
    end

    // Neighbor count and result flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nb_cnt   <= '0;
            res_full <= 1'b0;
        end else if (clr) begin
            nb_cnt   <= '0;
            res_full <= 1'b0;
        end else begin
            if (ofm_fire) begin
                if (nb_cnt == k_last) begin
                    nb_cnt   <= '0;
                    res_full <= 1'b1;
                end else begin
                    nb_cnt <= nb_cnt + 1'b1;
                end
            end else if (res_fire) begin
                res_full <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: pol_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pol_ctrl #(
    parameter int IDX_WIDTH = pol_pkg::IDX_WIDTH,
    parameter int K_WIDTH   = pol_pkg::K_WIDTH
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          cfg_vld,
    input  pol_pkg::k_t        cfg_k,
    input  pol_pkg::idx_t      cfg_nip,
    input  wire logic          map_vld,
    input  wire logic [1:0]    idx_rdy,
    input  wire logic          out_vld,
    input  wire logic          out_rdy,
    output logic               cfg_rdy,
    output logic               map_rdy,
    output logic               idx_vld,
    output logic               clr,
    output pol_pkg::k_t        job_k
);

    // Beat count needs room for K times Nip/2
    localparam int BEAT_W = IDX_WIDTH + K_WIDTH;

    pol_pkg::pol_state_e   state_q;
    pol_pkg::pol_state_e   state_d;
    logic [K_WIDTH-1:0]    k_q;
    logic [IDX_WIDTH-1:0]  nip_q;
    logic [BEAT_W-1:0]     beat_cnt;
    logic [BEAT_W-1:0]     beat_total;
    logic [IDX_WIDTH-1:0]  out_cnt;
    logic                  cfg_fire;
    logic                  map_fire;
    logic                  out_fire;
    logic                  map_last;
    logic                  out_last;

    // ================================================
    // Handshakes seen by the outside
    // ================================================
    assign cfg_rdy  = (state_q == pol_pkg::IDLE);
    assign clr      = (state_q == pol_pkg::IDLE);
    // Map word goes to both cores at once, only when both can take it
    assign idx_vld  = map_vld && map_rdy;
    assign map_rdy  = (state_q == pol_pkg::MAPIN) && (&idx_rdy);
    assign job_k    = k_q;

    assign cfg_fire = cfg_vld && cfg_rdy;
    assign map_fire = map_vld && map_rdy;
    assign out_fire = out_vld && out_rdy;

    // Two points per map word
    assign beat_total = BEAT_W'(k_q) * BEAT_W'(nip_q >> 1);
    assign map_last   = map_fire && (beat_cnt == beat_total - 1'b1);
    assign out_last   = out_fire && (out_cnt == nip_q - 1'b1);

    // ================================================
    // Job FSM
    // ================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            pol_pkg::IDLE:    if (cfg_fire) state_d = pol_pkg::MAPIN;
            pol_pkg::MAPIN:   if (map_last) state_d = pol_pkg::WAITFNH;
            pol_pkg::WAITFNH: if (out_last) state_d = pol_pkg::IDLE;
            default:          state_d = pol_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pol_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Job config captured on accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_q   <= '0;
            nip_q <= '0;
        end else if (cfg_fire) begin
            k_q   <= cfg_k;
            nip_q <= cfg_nip;
        end
    end

    // ================================================
    // Beat and output counters
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            out_cnt  <= '0;
        end else if (clr) begin
            beat_cnt <= '0;
            out_cnt  <= '0;
        end else begin
            if (map_fire) beat_cnt <= beat_cnt + 1'b1;
            // Outputs may start before the last map word
            if (out_fire) out_cnt <= out_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: pol_pkg.sv
`default_nettype none

package pol_pkg;

    // ================================================
    // Default widths
    // ================================================
    // Point index, also the activation address
    parameter int IDX_WIDTH = 10;
    // One activation lane
    parameter int ACT_WIDTH = 8;
    // Lanes per activation vector
    parameter int LANES     = 4;
    // Neighbor count
    parameter int K_WIDTH   = 5;

    // ================================================
    // Vector types
    // ================================================
    typedef logic [IDX_WIDTH-1:0]       idx_t;
    typedef logic [ACT_WIDTH-1:0]       act_t;
    // Lane 0 sits in the low bits
    typedef logic [ACT_WIDTH*LANES-1:0] vec_t;
    typedef logic [K_WIDTH-1:0]         k_t;
    // Low half is the even point, core 0
    typedef logic [2*IDX_WIDTH-1:0]     map_t;

    // ================================================
    // Controller FSM
    // ================================================
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        MAPIN   = 2'b01,
        WAITFNH = 2'b11
    } pol_state_e;

endpackage

`default_nettype wire
